// ==== build.f ====
cache_pkg.sv
mem_pkg.sv
tag_store.sv
data_store.sv
cache_controller.sv
cache_top.sv
tb_memory.sv
tb_cache.sv

// ==== cache_controller.sv ====
`timescale 1ns/10ps

module cache_controller (
	input logic clk,
	input logic reset,

	input logic req,
	input mem_pkg::cpu_req_t cpu,
	output logic done,
	output cache_pkg::word_t read_data,

	output logic wb_valid,
	output mem_pkg::wb_req_t wb,
	input logic wb_done,
	output logic fill_valid,
	output mem_pkg::fill_req_t fill,
	input logic fill_resp,
	input cache_pkg::line_t fill_line,

	output cache_pkg::index_t index,
	output cache_pkg::tag_t tag,
	input logic hit,
	input cache_pkg::way_t hit_way,
	input cache_pkg::way_t victim_way,
	input cache_pkg::line_state_t victim,
	output cache_pkg::tag_update_t update,

	output logic [2:0] word_sel,
	output cache_pkg::way_t way,
	output logic word_we,
	output cache_pkg::word_t word_in,
	output logic line_we,
	output cache_pkg::line_t line_in,
	input cache_pkg::word_t word_out,
	input cache_pkg::line_t line_out
);

	typedef enum logic [1:0] {
		idle,
		respond,
		write_back,
		fill_wait
	} state_t;

	state_t state;
	cache_pkg::addr_fields_t req_addr;
	cache_pkg::addr_fields_t victim_addr;
	cache_pkg::addr_fields_t line_addr;
	logic lookup; // request sampled in idle
	logic wb_open; // write-back sent, wb_done not yet seen

	assign req_addr = cpu.addr;
	assign index = req_addr.index;
	assign tag = req_addr.tag;
	assign word_sel = req_addr.offset[5:3];
	assign lookup = (state == idle) && req;

	always_comb begin
		victim_addr = '0;
		victim_addr.tag = victim.tag;
		victim_addr.index = req_addr.index;
		line_addr = req_addr;
		line_addr.offset = '0;
	end

	// hit way for word access, victim way for write-back and fill
	assign way = hit ? hit_way : victim_way;
	assign word_we = lookup && hit && (cpu.op == mem_pkg::op_write);
	assign word_in = cpu.wdata;
	assign line_we = (state == fill_wait) && fill_resp;
	assign line_in = fill_line;

	always_comb begin
		update = '0;
		update.way = victim_way;
		update.tag = req_addr.tag;
		case (state)
			idle: begin
				if (req && hit) begin
					update.en = 1'b1;
					update.way = hit_way;
					update.kind = (cpu.op == mem_pkg::op_write) ?
						cache_pkg::upd_write_hit : cache_pkg::upd_touch;
				end
			end
			write_back: begin
				if (wb_done) begin
					update.en = 1'b1;
					update.kind = cache_pkg::upd_clean;
				end
			end
			fill_wait: begin
				if (fill_resp) begin
					update.en = 1'b1;
					update.kind = cache_pkg::upd_fill;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			done <= 1'b0;
			wb_valid <= 1'b0;
			fill_valid <= 1'b0;
		end else begin
			done <= 1'b0; // all strobes are single cycle
			wb_valid <= 1'b0;
			fill_valid <= 1'b0;
			case (state)
				idle: begin
					if (req) begin
						if (hit) begin
							state <= respond;
							done <= 1'b1;
						end else if (victim.valid && victim.dirty) begin
							state <= write_back;
							wb_valid <= 1'b1;
						end else begin
							state <= fill_wait;
							fill_valid <= 1'b1;
						end
					end
				end
				respond: state <= idle;
				write_back: begin
					if (wb_done) begin // victim now clean, go fetch
						state <= fill_wait;
						fill_valid <= 1'b1;
					end
				end
				fill_wait: begin
					if (fill_resp) state <= idle; // re-lookup will hit
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lookup) begin
			read_data <= word_out;
			wb.addr <= victim_addr;
			wb.line <= line_out;
			fill.addr <= line_addr;
		end
	end

	// tracks the memory side of a write-back
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_open <= 1'b0;
		end else if (wb_valid) begin
			wb_open <= 1'b1;
		end else if (wb_done) begin
			wb_open <= 1'b0;
		end
	end

	a_done_in_respond: assert property (@(posedge clk) disable iff (reset)
		done |-> state == respond);

	a_wb_pulse: assert property (@(posedge clk) disable iff (reset)
		wb_valid |=> !wb_valid);

	a_fill_pulse: assert property (@(posedge clk) disable iff (reset)
		fill_valid |=> !fill_valid);

	// fill may only follow a finished write-back
	a_fill_after_wb: assert property (@(posedge clk) disable iff (reset)
		fill_valid |-> !wb_open);

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

	localparam int word_bits = 64;
	localparam int words_per_line = 8;
	localparam int offset_bits = 6; // 64 byte lines
	localparam int set_count = 64;
	localparam int index_bits = 6;
	localparam int tag_bits = 52;

	typedef logic [word_bits-1:0] word_t;
	typedef logic [index_bits-1:0] index_t;
	typedef logic [tag_bits-1:0] tag_t;

	// word 0 sits in the low bits
	typedef logic [words_per_line-1:0][word_bits-1:0] line_t;

	// word select is offset[5:3]
	typedef struct packed {
		tag_t tag;
		index_t index;
		logic [offset_bits-1:0] offset;
	} addr_fields_t;

	typedef logic way_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} line_state_t;

	typedef enum logic [1:0] {
		upd_fill,
		upd_write_hit,
		upd_touch,
		upd_clean
	} update_kind_t;

	typedef struct packed {
		logic en;
		way_t way;
		update_kind_t kind;
		tag_t tag; // only used by fill
	} tag_update_t;

endpackage

// ==== cache_top.sv ====
`timescale 1ns/10ps

module cache_top (
	input logic clk,
	input logic reset,
	input logic req,
	input mem_pkg::cpu_req_t cpu,
	output logic done,
	output cache_pkg::word_t read_data,
	output logic wb_valid,
	output mem_pkg::wb_req_t wb,
	input logic wb_done,
	output logic fill_valid,
	output mem_pkg::fill_req_t fill,
	input logic fill_resp,
	input cache_pkg::line_t fill_line
);

	cache_pkg::index_t index;
	cache_pkg::tag_t tag;
	logic hit;
	cache_pkg::way_t hit_way;
	cache_pkg::way_t victim_way;
	cache_pkg::line_state_t victim;
	cache_pkg::tag_update_t update;

	logic [2:0] word_sel;
	cache_pkg::way_t way;
	logic word_we;
	cache_pkg::word_t word_in;
	logic line_we;
	cache_pkg::line_t line_in;
	cache_pkg::word_t word_out;
	cache_pkg::line_t line_out;

	tag_store u_tag_store (
		.clk(clk),
		.reset(reset),
		.index(index),
		.tag(tag),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim(victim),
		.update(update)
	);

	data_store u_data_store (
		.clk(clk),
		.index(index),
		.word_sel(word_sel),
		.way(way),
		.word_we(word_we),
		.word_in(word_in),
		.line_we(line_we),
		.line_in(line_in),
		.word_out(word_out),
		.line_out(line_out)
	);

	cache_controller u_controller (
		.clk(clk),
		.reset(reset),
		.req(req),
		.cpu(cpu),
		.done(done),
		.read_data(read_data),
		.wb_valid(wb_valid),
		.wb(wb),
		.wb_done(wb_done),
		.fill_valid(fill_valid),
		.fill(fill),
		.fill_resp(fill_resp),
		.fill_line(fill_line),
		.index(index),
		.tag(tag),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim(victim),
		.update(update),
		.word_sel(word_sel),
		.way(way),
		.word_we(word_we),
		.word_in(word_in),
		.line_we(line_we),
		.line_in(line_in),
		.word_out(word_out),
		.line_out(line_out)
	);

endmodule

// ==== data_store.sv ====
`timescale 1ns/10ps

module data_store (
	input logic clk,
	input cache_pkg::index_t index,
	input logic [2:0] word_sel,
	input cache_pkg::way_t way,
	input logic word_we,
	input cache_pkg::word_t word_in,
	input logic line_we,
	input cache_pkg::line_t line_in,
	output cache_pkg::word_t word_out,
	output cache_pkg::line_t line_out
);

	cache_pkg::line_t lines_q [2][cache_pkg::set_count];

	always_ff @(posedge clk) begin
		if (line_we) begin
			lines_q[way][index] <= line_in; // fill from memory
		end else if (word_we) begin
			lines_q[way][index][word_sel] <= word_in;
		end
	end

	assign line_out = lines_q[way][index]; // write-back source
	assign word_out = line_out[word_sel];

	// controller only fills in fill_wait and writes words in idle
	a_one_write_kind: assert property (@(posedge clk)
		!(word_we && line_we));

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

	localparam int addr_bits = 64;

	typedef logic [addr_bits-1:0] addr_t;

	typedef enum logic {
		op_read,
		op_write
	} cpu_op_t;

	typedef struct packed {
		cpu_op_t op;
		addr_t addr;
		cache_pkg::word_t wdata;
	} cpu_req_t;

	// line address, offset bits zero
	typedef struct packed {
		addr_t addr;
	} fill_req_t;

	typedef struct packed {
		addr_t addr;
		cache_pkg::line_t line;
	} wb_req_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_cache -o tb_cache -f build.f || exit 1
./obj_dir/tb_cache > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0

// ==== tag_store.sv ====
`timescale 1ns/10ps

module tag_store (
	input logic clk,
	input logic reset,
	input cache_pkg::index_t index,
	input cache_pkg::tag_t tag,
	output logic hit,
	output cache_pkg::way_t hit_way,
	output cache_pkg::way_t victim_way,
	output cache_pkg::line_state_t victim,
	input cache_pkg::tag_update_t update
);

	cache_pkg::line_state_t state_q [2][cache_pkg::set_count];
	logic [cache_pkg::set_count-1:0] lru_q; // holds the way to replace next
	logic [1:0] match;

	always_comb begin
		match[0] = state_q[0][index].valid && (state_q[0][index].tag == tag);
		match[1] = state_q[1][index].valid && (state_q[1][index].tag == tag);
	end

	assign hit = |match;
	assign hit_way = match[1];

	// an invalid way is always the lru one
	assign victim_way = lru_q[index];
	assign victim = state_q[victim_way][index];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < cache_pkg::set_count; s++) begin
				state_q[0][s].valid <= 1'b0;
				state_q[0][s].dirty <= 1'b0;
				state_q[1][s].valid <= 1'b0;
				state_q[1][s].dirty <= 1'b0;
			end
			lru_q <= '0;
		end else if (update.en) begin
			case (update.kind)
				cache_pkg::upd_fill: begin
					state_q[update.way][index].valid <= 1'b1;
					state_q[update.way][index].dirty <= 1'b0;
					state_q[update.way][index].tag <= update.tag;
				end
				cache_pkg::upd_write_hit: state_q[update.way][index].dirty <= 1'b1;
				cache_pkg::upd_clean: state_q[update.way][index].dirty <= 1'b0;
				default: ; // touch only moves lru
			endcase
			if (update.kind != cache_pkg::upd_clean) begin
				lru_q[index] <= ~update.way; // other way becomes lru
			end
		end
	end

	// fill must never load a tag already present in the other way
	a_no_double_hit: assert property (@(posedge clk) disable iff (reset)
		!(match[0] && match[1]));

endmodule

// ==== tb_cache.sv ====
`timescale 1ns/10ps

module tb_cache;

	logic clk = 1'b0;
	logic reset;
	logic req;
	mem_pkg::cpu_req_t cpu;
	logic done;
	cache_pkg::word_t read_data;
	logic wb_valid;
	mem_pkg::wb_req_t wb;
	logic wb_done;
	logic fill_valid;
	mem_pkg::fill_req_t fill;
	logic fill_resp;
	cache_pkg::line_t fill_line;

	cache_pkg::word_t ref_mem [logic [63:0]]; // words the processor wrote
	string test_name = "none";
	int errors = 0, err_base = 0, tests = 0;
	int fill_total = 0, wb_total = 0, fill_base = 0, wb_base = 0;
	int exp_fills = 0, exp_wbs = 0;
	logic quiet_chk = 1'b1;
	logic read_chk = 1'b0, count_chk = 1'b0, wb_chk = 1'b0, timed_out = 1'b0;
	logic [63:0] cur_addr = '0, exp_wb_addr = '0;
	logic [2:0] exp_wb_sel = '0;
	cache_pkg::word_t exp_data = '0, exp_wb_word = '0;

	always #4 clk = ~clk;

	cache_top UUT (.*);
	tb_memory u_memory (.*);

	always @(posedge clk) begin
		if (fill_valid) fill_total <= fill_total + 1;
		if (wb_valid) wb_total <= wb_total + 1;
	end

	a_quiet: assert property (@(posedge clk) disable iff (reset)
		quiet_chk |-> !(done || wb_valid || fill_valid))
		else begin
			$display("%s: a strobe went high before any request was made", test_name);
			errors++;
		end

	a_read_value: assert property (@(posedge clk) disable iff (reset)
		done && read_chk |-> read_data == exp_data)
		else begin
			$display("** Error %s: read expected %h, actual %h",
				test_name, exp_data, $sampled(read_data));
			errors++;
		end

	a_fill_addr: assert property (@(posedge clk) disable iff (reset)
		fill_valid |-> fill.addr == {cur_addr[63:6], 6'b0})
		else begin
			$display("** Error %s: fill address expected %h, actual %h",
				test_name, {cur_addr[63:6], 6'b0}, $sampled(fill));
			errors++;
		end

	a_traffic: assert property (@(posedge clk) disable iff (reset)
		done && count_chk |-> fill_total - fill_base == exp_fills
			&& wb_total - wb_base == exp_wbs)
		else begin
			$display("** Error %s: fills/write-backs expected %0d/%0d, actual %0d/%0d",
				test_name, exp_fills, exp_wbs, fill_total - fill_base, wb_total - wb_base);
			errors++;
		end

	a_wb_line: assert property (@(posedge clk) disable iff (reset)
		wb_valid && wb_chk |-> wb.addr == exp_wb_addr && wb.line[exp_wb_sel] == exp_wb_word)
		else begin
			$display("** Error %s: write-back expected %h/%h, actual %h/%h", test_name,
				exp_wb_addr, exp_wb_word, wb.addr, wb.line[exp_wb_sel]);
			errors++;
		end

	function automatic logic [63:0] make_addr(input int tag, input int set, input int word);
		return {52'(tag), 6'(set), 3'(word), 3'b000};
	endfunction

	function automatic cache_pkg::word_t ref_word(input logic [63:0] addr);
		if (ref_mem.exists(addr)) return ref_mem[addr];
		return {32'ha5a5a5a5 ^ addr[63:32], addr[31:0]};
	endfunction

	task automatic start_test(input string name);
		test_name = name;
		err_base = errors;
	endtask

	task automatic end_test();
		@(posedge clk); // lets the last edge's checks land
		tests++;
		$display("%s finished with %0d errors", test_name, errors - err_base);
	endtask

	// fills or wbs below zero leave the traffic unchecked
	task automatic access(input mem_pkg::cpu_op_t op, input logic [63:0] addr,
			input cache_pkg::word_t wdata, input int fills, input int wbs);
		int waited;
		waited = 0;
		if (timed_out) return;
		@(posedge clk);
		cur_addr <= addr;
		exp_data <= ref_word(addr);
		read_chk <= (op == mem_pkg::op_read);
		count_chk <= (fills >= 0);
		exp_fills <= fills;
		exp_wbs <= wbs;
		fill_base <= fill_total;
		wb_base <= wb_total;
		req <= 1'b1;
		cpu.op <= op;
		cpu.addr <= addr;
		cpu.wdata <= wdata;
		do begin
			@(posedge clk);
			waited++;
		end while (!done && waited < 300);
		req <= 1'b0;
		if (!done) begin
			$display("%s: no done within 300 cycles for address %h", test_name, addr);
			timed_out = 1'b1;
			errors++;
		end else if (op == mem_pkg::op_write) begin
			ref_mem[addr] = wdata;
		end
	endtask

	initial begin
		logic [63:0] a;
		cache_pkg::word_t v;
		mem_pkg::cpu_op_t op;
		void'($urandom(19841));
		reset = 1'b1;
		req = 1'b0;
		cpu = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		start_test("reset_quiet");
		repeat (12) @(posedge clk);
		quiet_chk <= 1'b0;
		end_test();

		start_test("read_miss_fill");
		a = make_addr(16, 1, 3);
		access(mem_pkg::op_read, a, '0, 1, 0);
		access(mem_pkg::op_read, a, '0, 0, 0); // now a hit
		end_test();

		start_test("write_hit");
		a = make_addr(16, 1, 5);
		v = 64'h0123_4567_89ab_cdef;
		access(mem_pkg::op_write, a, v, 0, 0);
		access(mem_pkg::op_read, a, '0, 0, 0);
		end_test();

		start_test("lru_replace");
		access(mem_pkg::op_read, make_addr(32, 2, 0), '0, 1, 0);
		access(mem_pkg::op_read, make_addr(33, 2, 1), '0, 1, 0);
		access(mem_pkg::op_read, make_addr(32, 2, 2), '0, 0, 0);
		access(mem_pkg::op_read, make_addr(34, 2, 3), '0, 1, 0); // evicts line 33
		access(mem_pkg::op_read, make_addr(32, 2, 4), '0, 0, 0);
		access(mem_pkg::op_read, make_addr(33, 2, 5), '0, 1, 0);
		end_test();

		start_test("dirty_evict");
		a = make_addr(48, 4, 6);
		v = 64'hfeed_0000_beef_0006;
		access(mem_pkg::op_write, a, v, 1, 0);
		access(mem_pkg::op_read, make_addr(49, 4, 0), '0, 1, 0);
		wb_chk <= 1'b1;
		exp_wb_addr <= {a[63:6], 6'b0};
		exp_wb_sel <= 3'd6;
		exp_wb_word <= v;
		access(mem_pkg::op_read, make_addr(50, 4, 0), '0, 1, 1);
		wb_chk <= 1'b0;
		access(mem_pkg::op_read, a, '0, 1, 0); // comes back from memory
		end_test();

		start_test("random_mix");
		for (int i = 0; i < 80; i++) begin
			op = ($urandom % 2 == 1) ? mem_pkg::op_write : mem_pkg::op_read;
			a = make_addr(64 + $urandom % 4, 5 + $urandom % 2, $urandom % 8);
			access(op, a, {$urandom, $urandom}, -1, -1);
		end
		end_test();

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tb_memory.sv ====
`timescale 1ns/10ps

module tb_memory (
	input logic clk,
	input logic reset,
	input logic wb_valid,
	input mem_pkg::wb_req_t wb,
	output logic wb_done,
	input logic fill_valid,
	input mem_pkg::fill_req_t fill,
	output logic fill_resp,
	output cache_pkg::line_t fill_line
);

	cache_pkg::word_t mem [logic [63:0]]; // only words written back

	function automatic cache_pkg::word_t read_word(input logic [63:0] addr);
		if (mem.exists(addr)) return mem[addr];
		return {32'ha5a5a5a5 ^ addr[63:32], addr[31:0]}; // power-up contents
	endfunction

	// one request at a time, answered after 1 to 12 cycles
	initial begin
		mem_pkg::wb_req_t wb_q;
		mem_pkg::fill_req_t fill_q;
		logic is_wb;
		int delay;
		wb_done = 1'b0;
		fill_resp = 1'b0;
		fill_line = '0;
		forever begin
			@(posedge clk);
			if (!reset && (wb_valid || fill_valid)) begin
				is_wb = wb_valid;
				wb_q = wb;
				fill_q = fill;
				delay = 1 + int'($urandom % 12);
				for (int i = 0; i < delay; i++) @(posedge clk);
				if (is_wb) begin
					for (int w = 0; w < 8; w++) begin
						mem[wb_q.addr + 64'(8 * w)] = wb_q.line[w];
					end
					wb_done <= 1'b1;
				end else begin
					for (int w = 0; w < 8; w++) begin
						fill_line[w] <= read_word(fill_q.addr + 64'(8 * w));
					end
					fill_resp <= 1'b1;
				end
				@(posedge clk);
				wb_done <= 1'b0; // single cycle pulse
				fill_resp <= 1'b0;
			end
		end
	end

endmodule
